/* Makefile */
VERILATOR = verilator
TOP       = motor_subsys_tb
RTL_TOP   = motor_subsys
FILELIST  = motor_subsys.f
FLAGS     = --binary --timing --assert -j 0
RUN_ARGS  = +verilator+error+limit+1000
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/drive_uart_tx.sv */
/*
 * 8N1 UART transmitter for one drive motor.
 * Sends the current command byte back to back, latched at each start bit.
 */
module drive_uart_tx (
    input  logic                  clock,    // System clock
    input  logic                  arst_n,   // Async reset, active low
    input  motor_pkg::drive_cmd_t cmd,      // Command byte to repeat
    output logic                  uart_tx   // Serial line, idle high
);

    localparam int BAUD_W = $clog2(motor_pkg::BAUD_DIV);

    logic [BAUD_W-1:0]            baud_cnt;  // Clocks within a bit
    logic [3:0]                   bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [motor_pkg::DATA_W-1:0] shifter;   // Remaining data bits
    logic                         bit_end;   // Last clock of a bit
    logic                         frame_end; // Last clock of the stop bit

    assign bit_end   = (baud_cnt == BAUD_W'(motor_pkg::BAUD_DIV - 1));
    assign frame_end = bit_end &&
                       (bit_idx == 4'(motor_pkg::UART_FRAME_BITS - 1));

    ////////////////////////////////
    // Bit timing
    ////////////////////////////////
    // Reset parks at the end of a stop bit so the first frame starts at once
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            baud_cnt <= BAUD_W'(motor_pkg::BAUD_DIV - 1);
            bit_idx  <= 4'(motor_pkg::UART_FRAME_BITS - 1);
            uart_tx  <= 1'b1;                       // Line idle
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (frame_end) begin
                bit_idx <= '0;
                uart_tx <= 1'b0;                    // Start bit
            end else begin
                bit_idx <= bit_idx + 4'd1;
                uart_tx <= shifter[0];              // LSB first, then stop
            end
        end else begin
            baud_cnt <= baud_cnt + BAUD_W'(1);
        end
    end

    ////////////////////////////////
    // Data shifter
    ////////////////////////////////
    always_ff @(posedge clock) begin
        if (frame_end) begin
            shifter <= cmd;                         // Frame content frozen here
        end else if (bit_end) begin
            shifter <= {1'b1, shifter[7:1]};        // Ones fill in the stop bit
        end
    end

endmodule

/* logic/motor_pkg.sv */
/*
 * Shared register map, timing constants and bus types for the motor datapath.
 * Every RTL block takes what it needs from here by scoped name.
 */
package motor_pkg;

    ////////////////////////////////
    // Register map
    ////////////////////////////////
    localparam int ADDR_W     = 6;      // Register address width
    localparam int DATA_W     = 8;      // Register data width
    localparam int NUM_MOTORS = 4;      // Drive motors, also servo count
    localparam int DRIVE_BASE = 0;      // Drive commands at 0..3
    localparam int SERVO_BASE = 4;      // Servo positions at 4..7

    ////////////////////////////////
    // Output timing
    ////////////////////////////////
    localparam int BAUD_DIV        = 8;    // Clocks per UART bit
    localparam int UART_FRAME_BITS = 10;   // Start, 8 data, stop
    localparam int PWM_PERIOD      = 256;  // Clocks per servo period

    ////////////////////////////////
    // Bus types
    ////////////////////////////////
    // Drive command byte, as the motor controller expects it on the UART
    typedef struct packed {
        logic       brake;              // Brake request
        logic       enable;             // Motor enable
        logic       direction;          // Rotation direction
        logic [4:0] speed;              // Speed magnitude
    } drive_cmd_t;

    // Register access from the SPI target
    typedef struct packed {
        logic              write_en;    // One-cycle write strobe
        logic              read_en;     // One-cycle read strobe
        logic [ADDR_W-1:0] address;     // Register address
        logic [DATA_W-1:0] wr_data;     // Write payload
    } reg_req_t;

endpackage

/* logic/motor_regs.sv */
/*
 * Register file behind the SPI target.
 * Holds the four drive commands and the four servo positions.
 */
module motor_regs (
    input  logic                                               clock,     // System clock
    input  logic                                               arst_n,    // Async reset
    input  motor_pkg::reg_req_t                                req,       // From SPI target
    output logic [motor_pkg::DATA_W-1:0]                       rd_data,   // Registered read
    output motor_pkg::drive_cmd_t [motor_pkg::NUM_MOTORS-1:0]  drive_cmd, // To UARTs
    output logic [motor_pkg::NUM_MOTORS-1:0][motor_pkg::DATA_W-1:0] servo_pos // To PWMs
);

    logic [motor_pkg::DATA_W-1:0] rd_mux;           // Combinational readback

    ////////////////////////////////
    // Write decode
    ////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            drive_cmd <= '0;
            servo_pos <= '0;
        end else if (req.write_en) begin
            for (int i = 0; i < motor_pkg::NUM_MOTORS; i++) begin
                if (req.address == motor_pkg::ADDR_W'(motor_pkg::DRIVE_BASE + i)) begin
                    drive_cmd[i] <= motor_pkg::drive_cmd_t'(req.wr_data);
                end
                if (req.address == motor_pkg::ADDR_W'(motor_pkg::SERVO_BASE + i)) begin
                    servo_pos[i] <= req.wr_data;
                end
            end
            // Addresses 8..63 fall through untouched
        end
    end

    ////////////////////////////////
    // Read mux
    ////////////////////////////////
    always_comb begin
        rd_mux = '0;                                // Unmapped reads as zero
        for (int i = 0; i < motor_pkg::NUM_MOTORS; i++) begin
            if (req.address == motor_pkg::ADDR_W'(motor_pkg::DRIVE_BASE + i)) begin
                rd_mux = drive_cmd[i];
            end
            if (req.address == motor_pkg::ADDR_W'(motor_pkg::SERVO_BASE + i)) begin
                rd_mux = servo_pos[i];
            end
        end
    end

    // One cycle after read_en, SPI target picks it up the cycle after
    always_ff @(posedge clock) begin
        if (req.read_en) begin
            rd_data <= rd_mux;
        end
    end

endmodule

/* logic/motor_subsys.sv */
/*
 * Motor control top level: SPI register access driving four drive UARTs
 * and four arm servo PWMs.
 */
module motor_subsys (
    input  logic       clock,       // System clock
    input  logic       arst_n,      // Async reset, active low
    input  logic       spi_clock,   // Host SPI clock
    input  logic       cs_n,        // Host chip select
    input  logic       mosi,        // Host data in
    output logic       miso,        // Host data out
    output logic [3:0] sd_uart,     // Swerve drive UART lines
    output logic [3:0] servo_pwm    // Arm servo PWM waves
);

    motor_pkg::reg_req_t                                       req;
    logic [motor_pkg::DATA_W-1:0]                              rd_data;
    motor_pkg::drive_cmd_t [motor_pkg::NUM_MOTORS-1:0]         drive_cmd;
    logic [motor_pkg::NUM_MOTORS-1:0][motor_pkg::DATA_W-1:0]   servo_pos;

    ////////////////////////////////
    // Host access
    ////////////////////////////////
    spi_target u_spi (
        .clock     (clock),
        .arst_n    (arst_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .rd_data   (rd_data),
        .miso      (miso),
        .req       (req)
    );

    motor_regs u_regs (
        .clock     (clock),
        .arst_n    (arst_n),
        .req       (req),
        .rd_data   (rd_data),
        .drive_cmd (drive_cmd),
        .servo_pos (servo_pos)
    );

    ////////////////////////////////
    // Motor outputs
    ////////////////////////////////
    for (genvar i = 0; i < motor_pkg::NUM_MOTORS; i++) begin : gen_drive
        drive_uart_tx u_uart (
            .clock   (clock),
            .arst_n  (arst_n),
            .cmd     (drive_cmd[i]),
            .uart_tx (sd_uart[i])
        );
    end

    for (genvar i = 0; i < motor_pkg::NUM_MOTORS; i++) begin : gen_servo
        servo_pwm u_pwm (
            .clock    (clock),
            .arst_n   (arst_n),
            .position (servo_pos[i]),
            .pwm      (servo_pwm[i])
        );
    end

endmodule

/* logic/servo_pwm.sv */
/*
 * Single servo PWM, 256 clocks per period.
 * High for the first position clocks, position takes effect at the wrap.
 */
module servo_pwm (
    input  logic                         clock,     // System clock
    input  logic                         arst_n,    // Async reset, active low
    input  logic [motor_pkg::DATA_W-1:0] position,  // High time in clocks
    output logic                         pwm        // Servo drive
);

    localparam int CNT_W = $clog2(motor_pkg::PWM_PERIOD);

    logic [CNT_W-1:0]             cnt;          // Free-running period count
    logic [CNT_W-1:0]             cnt_nxt;
    logic [motor_pkg::DATA_W-1:0] shadow;       // Position for this period
    logic [motor_pkg::DATA_W-1:0] shadow_nxt;

    always_comb begin
        cnt_nxt    = cnt + CNT_W'(1);           // Natural 8-bit wrap
        shadow_nxt = (cnt == CNT_W'(motor_pkg::PWM_PERIOD - 1)) ? position : shadow;
    end

    // Output registered against the next count, no compare glitches
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            shadow <= '0;
            pwm    <= 1'b0;
        end else begin
            cnt    <= cnt_nxt;
            shadow <= shadow_nxt;
            pwm    <= (cnt_nxt < shadow_nxt);
        end
    end

endmodule

/* logic/spi_target.sv */
/*
 * SPI mode 0 target, oversampled in the system clock domain.
 * Turns 16-bit host transfers into register read and write strobes.
 */
module spi_target (
    input  logic                        clock,      // System clock
    input  logic                        arst_n,     // Async reset, active low
    input  logic                        spi_clock,  // Host SPI clock
    input  logic                        cs_n,       // Chip select, active low
    input  logic                        mosi,       // Host data in
    input  logic [motor_pkg::DATA_W-1:0] rd_data,   // Registered read data
    output logic                        miso,       // Target data out
    output motor_pkg::reg_req_t         req         // Register request
);

    logic [2:0]                      sclk_sync;     // Sync pair plus edge history
    logic [1:0]                      cs_sync;       // Chip select sync
    logic [1:0]                      mosi_sync;     // Data sync
    logic                            sclk_rise;     // Synced rising edge
    logic                            sclk_fall;     // Synced falling edge
    logic                            cs_active;     // Transfer in progress
    logic [3:0]                      bit_cnt;       // Rising edges this transfer
    logic [2*motor_pkg::DATA_W-1:0]  shift_in;      // Incoming word
    logic [motor_pkg::DATA_W-1:0]    shift_out;     // Outgoing read data
    logic                            write_en_q;
    logic                            read_en_q;
    logic                            load_out;      // rd_data valid next edge
    logic [motor_pkg::ADDR_W-1:0]    addr_q;
    logic [motor_pkg::DATA_W-1:0]    wdata_q;

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_active = ~cs_sync[1];

    ////////////////////////////////
    // Synchronizers
    ////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sclk_sync <= '0;
            cs_sync   <= 2'b11;                     // Idle deselected
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clock};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    ////////////////////////////////
    // Receive side and strobes
    ////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt    <= '0;
            write_en_q <= 1'b0;
            read_en_q  <= 1'b0;
            load_out   <= 1'b0;
        end else begin
            write_en_q <= 1'b0;                     // Strobes default low
            read_en_q  <= 1'b0;
            load_out   <= read_en_q;                // regs answer one cycle later
            if (!cs_active) begin
                bit_cnt <= '0;                      // Deselect restarts framing
            end else if (sclk_rise) begin
                bit_cnt    <= bit_cnt + 4'd1;       // Wraps after 16 bits
                read_en_q  <= (bit_cnt == 4'd7) & ~shift_in[6];   // Bit 15 low
                write_en_q <= (bit_cnt == 4'd15) & shift_in[14];  // Bit 15 high
            end
        end
    end

    // Shift data, capture address and payload
    always_ff @(posedge clock) begin
        if (cs_active && sclk_rise) begin
            shift_in <= {shift_in[14:0], mosi_sync[1]};
            if (bit_cnt == 4'd7) begin
                addr_q <= {shift_in[4:0], mosi_sync[1]};   // Bits 13..8
            end
            if (bit_cnt == 4'd15) begin
                wdata_q <= {shift_in[6:0], mosi_sync[1]};  // Bits 7..0
            end
        end
    end

    ////////////////////////////////
    // Transmit side
    ////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            miso      <= 1'b0;
            shift_out <= '0;
        end else if (!cs_active) begin
            miso      <= 1'b0;
            shift_out <= '0;                        // Writes shift out zeros
        end else if (load_out) begin
            shift_out <= rd_data;
        end else if (sclk_fall && bit_cnt[3]) begin // Data phase, bits 7..0
            miso      <= shift_out[7];
            shift_out <= {shift_out[6:0], 1'b0};
        end
    end

    assign req = '{write_en: write_en_q,
                   read_en:  read_en_q,
                   address:  addr_q,
                   wr_data:  wdata_q};

endmodule

/* motor_subsys.f */
logic/motor_pkg.sv
logic/spi_target.sv
logic/motor_regs.sv
logic/drive_uart_tx.sv
logic/servo_pwm.sv
logic/motor_subsys.sv
sim/motor_subsys_sva.sv
sim/motor_subsys_checker.sv
sim/motor_subsys_tb.sv

/* sim/motor_subsys_checker.sv */
/*
 * Watches the DUT outputs, decodes drive UART frames and servo duty, and
 * compares them with the expected values handed in by the testbench.
 */
module motor_subsys_checker (
    input logic       clock,            // System clock
    input logic       arst_n,           // Async reset, active low
    input logic [3:0] sd_uart,          // Drive UART lines
    input logic [3:0] servo_pwm         // Servo PWM lines
);

    localparam int BIT_CLKS   = motor_pkg::BAUD_DIV;
    localparam int FRAME_CLKS = motor_pkg::UART_FRAME_BITS * motor_pkg::BAUD_DIV;

    int unsigned cyc;                   // Rising edges since reset release
    int errors      = 0;
    int test_errors = 0;
    int tests_run   = 0;
    int checks      = 0;

    // Frame and PWM period phase both follow from this count
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) cyc <= 0;
        else         cyc <= cyc + 1;
    end

    ////////////////////////////////
    // Reporting
    ////////////////////////////////
    task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %02h, expected %02h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report(input string why);
        $display("error at %0t: %s", $time, why);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) $display("test %0d %s: ok", tests_run, name);
        else                  $display("test %0d %s: %0d errors", tests_run, name, test_errors);
        test_errors = 0;
    endtask

    ////////////////////////////////
    // Output decoding
    ////////////////////////////////
    // Each bit sampled at its middle
    task automatic decode_frame(input int k, output logic [9:0] bits);
        do @(negedge clock); while ((cyc - 1) % FRAME_CLKS != BIT_CLKS / 2);
        for (int b = 0; b < motor_pkg::UART_FRAME_BITS; b++) begin
            if (b > 0) repeat (BIT_CLKS) @(negedge clock);
            bits[b] = sd_uart[k];
        end
    endtask

    task automatic check_uart(input int k, input logic [7:0] exp);
        logic [9:0]            bits;
        motor_pkg::drive_cmd_t cmd;
        decode_frame(k, bits);                              // First frame dropped
        decode_frame(k, bits);
        if (bits[0] !== 1'b0 || bits[9] !== 1'b1) begin
            report($sformatf("framing error on sd_uart[%0d]", k));
        end
        cmd = motor_pkg::drive_cmd_t'(bits[8:1]);           // LSB first on the line
        compare($sformatf("sd_uart[%0d] byte", k), bits[8:1], exp);
        compare($sformatf("sd_uart[%0d] brake", k), 8'(cmd.brake), 8'(exp[7]));
        compare($sformatf("sd_uart[%0d] enable", k), 8'(cmd.enable), 8'(exp[6]));
        compare($sformatf("sd_uart[%0d] direction", k), 8'(cmd.direction), 8'(exp[5]));
        compare($sformatf("sd_uart[%0d] speed", k), 8'(cmd.speed), 8'(exp[4:0]));
    endtask

    task automatic check_servo(input int k, input logic [7:0] exp);
        int high;
        high = 0;
        do @(negedge clock); while (cyc % motor_pkg::PWM_PERIOD != 0);
        repeat (motor_pkg::PWM_PERIOD) @(negedge clock);    // Skip one full period
        for (int i = 0; i < motor_pkg::PWM_PERIOD; i++) begin
            if (servo_pwm[k]) high++;
            @(negedge clock);
        end
        if (high >= motor_pkg::PWM_PERIOD) begin
            report($sformatf("servo_pwm[%0d] stuck high for a whole period", k));
        end
        compare($sformatf("servo_pwm[%0d] high clocks", k), 8'(high), exp);
    endtask

endmodule

/* sim/motor_subsys_sva.sv */
/*
 * Assertions on the register strobes of the SPI target, bound into spi_target.
 */
module motor_subsys_sva (
    input logic                clock,       // System clock
    input logic                arst_n,      // Async reset, active low
    input logic                cs_n,        // Raw chip select
    input motor_pkg::reg_req_t req          // Strobes under watch
);

    int unsigned fail_count = 0;            // Summed into the final count

    a_strobe_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
        !(req.write_en && req.read_en))
        else begin
            $error("read and write strobes high in the same cycle");
            fail_count++;
        end

    a_write_single: assert property (@(posedge clock) disable iff (!arst_n)
        req.write_en |=> !req.write_en)
        else begin
            $error("write strobe longer than one cycle");
            fail_count++;
        end

    a_read_single: assert property (@(posedge clock) disable iff (!arst_n)
        req.read_en |=> !req.read_en)
        else begin
            $error("read strobe longer than one cycle");
            fail_count++;
        end

    // Strobes only inside a selected transfer
    a_strobe_selected: assert property (@(posedge clock) disable iff (!arst_n)
        (req.write_en || req.read_en) |-> !cs_n)
        else begin
            $error("register strobe while chip select is high");
            fail_count++;
        end

endmodule

bind spi_target motor_subsys_sva u_sva (
    .clock  (clock),
    .arst_n (arst_n),
    .cs_n   (cs_n),
    .req    (req)
);

/* sim/motor_subsys_tb.sv */
/*
 * Testbench top for the motor datapath. SPI register traffic is driven on
 * the falling clock edge; expected values come from a reference register array.
 */
module motor_subsys_tb;

    localparam logic [31:0] SEED = 32'h9939284b;
    localparam int SPI_HALF   = 10;             // Clocks per SPI half period
    localparam int RUN_LEN    = 40;             // Random writes in the last test
    localparam int NUM_REGS   = 2 * motor_pkg::NUM_MOTORS;
    localparam int XFER_CLKS  = 2 * SPI_HALF * 16 + 4 * SPI_HALF;
    localparam int OUT_CLKS   = 3 * motor_pkg::PWM_PERIOD;    // Worst output check
    localparam int NUM_XFERS  = 8 + 16 + 4 + 4 + 10 + 2 * RUN_LEN;
    localparam int NUM_OUTS   = 4 + 4 + 8 + RUN_LEN;
    localparam int LIMIT_CLKS = 2 * (NUM_XFERS * XFER_CLKS + NUM_OUTS * OUT_CLKS) + 100;

    logic        clock;
    logic        arst_n;
    logic        spi_clock;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    logic [3:0]  sd_uart;
    logic [3:0]  servo_pwm;
    logic [7:0]  ref_regs [NUM_REGS];           // What each write leaves behind
    logic [31:0] rng;                           // xorshift state

    motor_subsys DUT (.clock, .arst_n, .spi_clock, .cs_n, .mosi, .miso, .sd_uart, .servo_pwm);
    motor_subsys_checker chk (.clock, .arst_n, .sd_uart, .servo_pwm);

    initial clock = 1'b0;
    always #5 clock = ~clock;

    ////////////////////////////////
    // Reference model
    ////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] expected_read(input logic [5:0] addr);
        if (addr < 6'(NUM_REGS)) return ref_regs[addr[2:0]];
        return 8'h00;                           // Outside the map
    endfunction

    task automatic next_random(output logic [31:0] word);
        rng  = xorshift32(rng);
        word = rng;
    endtask

    ////////////////////////////////
    // SPI host, mode 0
    ////////////////////////////////
    task automatic spi_transfer(input logic [15:0] word, output logic [7:0] rx);
        rx   = '0;
        cs_n = 1'b0;
        repeat (SPI_HALF) @(negedge clock);
        for (int i = 15; i >= 0; i--) begin
            mosi = word[i];                     // MSB first
            repeat (SPI_HALF) @(negedge clock);
            spi_clock = 1'b1;
            if (i < 8) rx[i] = miso;            // Host samples on the rise
            repeat (SPI_HALF) @(negedge clock);
            spi_clock = 1'b0;
        end
        repeat (SPI_HALF) @(negedge clock);
        cs_n = 1'b1;
        repeat (SPI_HALF) @(negedge clock);
    endtask

    task automatic reg_write(input logic [5:0] addr, input logic [7:0] data);
        logic [7:0] unused_rx;
        spi_transfer({2'b10, addr, data}, unused_rx);
        if (addr < 6'(NUM_REGS)) ref_regs[addr[2:0]] = data;
    endtask

    task automatic reg_read_check(input logic [5:0] addr);
        logic [7:0] rx;
        spi_transfer({2'b00, addr, 8'h00}, rx);
        chk.compare($sformatf("readback[%0d]", addr), rx, expected_read(addr));
    endtask

    task automatic check_output(input int idx);
        if (idx < motor_pkg::SERVO_BASE) chk.check_uart(idx, expected_read(6'(idx)));
        else chk.check_servo(idx - motor_pkg::SERVO_BASE, expected_read(6'(idx)));
    endtask

    ////////////////////////////////
    // Tests
    ////////////////////////////////
    initial begin
        logic [31:0] word;
        logic [5:0]  addr;
        int          errors_total;
        rng       = SEED;
        arst_n    = 1'b0;
        spi_clock = 1'b0;
        cs_n      = 1'b1;
        mosi      = 1'b0;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        repeat (10) @(negedge clock);
        chk.compare("sd_uart", 8'(sd_uart), 8'h0f);        // Idle high in reset
        chk.compare("servo_pwm", 8'(servo_pwm), 8'h00);
        chk.compare("miso", 8'(miso), 8'h00);
        arst_n = 1'b1;
        for (int a = 0; a < NUM_REGS; a++) reg_read_check(6'(a));
        chk.finish_test("reset values");

        for (int a = 0; a < NUM_REGS; a++) begin
            next_random(word);
            reg_write(6'(a), word[7:0]);
        end
        for (int a = 0; a < NUM_REGS; a++) reg_read_check(6'(a));
        chk.finish_test("register readback");

        for (int k = 0; k < motor_pkg::NUM_MOTORS; k++) begin
            next_random(word);
            reg_write(6'(motor_pkg::DRIVE_BASE + k), word[7:0]);
            check_output(motor_pkg::DRIVE_BASE + k);
        end
        chk.finish_test("drive uart frames");

        for (int k = 0; k < motor_pkg::NUM_MOTORS; k++) begin
            next_random(word);
            reg_write(6'(motor_pkg::SERVO_BASE + k), word[7:0]);
            check_output(motor_pkg::SERVO_BASE + k);
        end
        chk.finish_test("servo duty");

        next_random(word);
        addr = 6'(NUM_REGS) + word[13:8] % 6'd56;           // 8..63
        reg_write(addr, word[7:0]);
        reg_read_check(addr);
        for (int a = 0; a < NUM_REGS; a++) reg_read_check(6'(a));
        for (int a = 0; a < NUM_REGS; a++) check_output(a);
        chk.finish_test("unmapped write");

        for (int n = 0; n < RUN_LEN; n++) begin
            next_random(word);
            addr = {2'b00, word[11:8]};                     // Half land outside the map
            reg_write(addr, word[7:0]);
            reg_read_check(addr);
            if (addr < 6'(NUM_REGS)) check_output(int'(addr));
        end
        chk.finish_test("random run");

        errors_total = chk.errors + int'(DUT.u_spi.u_sva.fail_count);
        $display("tests %0d, checks %0d, errors %0d", chk.tests_run, chk.checks, errors_total);
        if (errors_total == 0) $display("RESULT: PASS");
        else                   $display("RESULT: FAIL");
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        repeat (LIMIT_CLKS) @(posedge clock);
        $display("timeout: run did not finish within %0d clocks", LIMIT_CLKS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
